//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_lsu
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
SIM_ARGS  ?= +verilator+error+limit+100
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Result: failure reported, see $(LOG)"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "Result: run ended early, see $(LOG)"; exit 1; fi
	@echo "Result: no failure reported"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- data_ram.sv
`timescale 1ns/1ns
`include "lsu_params.svh"

module data_ram #(
    parameter int ADDR_W = `LSU_RAM_AW
) (
    input  logic      clk_i,
    mem_bus_if.slave  bus
);
    import lsu_pkg::*;

    localparam int LANES = `LSU_DATA_W / 8;

    mem_word_u         mem [2**ADDR_W];
    mem_word_u         wr_word;
    logic [ADDR_W-1:0] word_addr;

    assign word_addr = bus.addr[ADDR_W+1:2];
    assign wr_word   = bus.wdata;

    // Per-lane write
    always_ff @(posedge clk_i) begin
        if (bus.wr) begin
            for (int i = 0; i < LANES; i++) begin
                if (bus.byte_en[i]) begin
                    mem[word_addr].bytes[i] <= wr_word.bytes[i];
                end
            end
        end
    end

    // Registered read, holds between reads
    always_ff @(posedge clk_i) begin
        if (bus.rd) begin
            bus.rdata <= mem[word_addr].word;
        end
    end

endmodule

//--- filelist.f
+incdir+.
lsu_pkg.sv
mem_bus_if.sv
mem_access.sv
data_ram.sv
load_merge.sv
lsu_top.sv
lsu_asserts.sv
tb_lsu.sv

//--- load_merge.sv
`timescale 1ns/1ns
`include "lsu_params.svh"

module load_merge (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  lsu_pkg::access_op_e     mem_access_op_i,
    input  lsu_pkg::access_sz_e     mem_access_sz_i,
    input  logic [1:0]              addr_lo_i,
    input  logic                    flag_unsigned_i,
    input  logic                    blocked_i,
    input  logic [4:0]              reg_addr_i,
    input  logic [`LSU_DATA_W-1:0]  data_i,
    input  logic [`LSU_DATA_W-1:0]  mem_rdata_i,
    output logic                    wb_en_o,
    output logic [4:0]              wb_reg_addr_o,
    output logic [`LSU_DATA_W-1:0]  wb_data_o
);
    import lsu_pkg::*;

    access_op_e             op_q;
    access_sz_e             sz_q;
    logic [1:0]             addr_lo_q;
    logic                   unsigned_q;
    logic [`LSU_DATA_W-1:0] old_q;      // Register value before the load

    mem_word_u              rd_word;
    logic [7:0]             sel_byte;
    logic [15:0]            sel_half;
    logic [4:0]             left_shift;
    logic [4:0]             right_shift;
    logic [`LSU_DATA_W-1:0] left_keep;
    logic [`LSU_DATA_W-1:0] right_keep;
    logic [`LSU_DATA_W-1:0] load_data;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            op_q          <= OP_D2R;
            sz_q          <= SZ_BYTE;
            addr_lo_q     <= 2'b00;
            unsigned_q    <= 1'b0;
            old_q         <= '0;
            wb_reg_addr_o <= 5'd0;
            wb_en_o       <= 1'b0;
        end else begin
            op_q          <= mem_access_op_i;
            sz_q          <= mem_access_sz_i;
            addr_lo_q     <= addr_lo_i;
            unsigned_q    <= flag_unsigned_i;
            old_q         <= data_i;
            wb_reg_addr_o <= reg_addr_i;
            // Stores never write back
            wb_en_o       <= ~blocked_i &&
                             (mem_access_op_i == OP_M2R || mem_access_op_i == OP_D2R);
        end
    end

    assign rd_word  = mem_rdata_i;
    assign sel_byte = rd_word.bytes[addr_lo_q];
    assign sel_half = rd_word.halves[addr_lo_q[1]];

    assign left_shift  = {2'd3 - addr_lo_q, 3'b000};
    assign right_shift = {addr_lo_q, 3'b000};

    // Low (3-a) bytes of the old value survive a left load
    assign left_keep  = ~({`LSU_DATA_W{1'b1}} << left_shift);
    // Top a bytes survive a right load
    assign right_keep = ~({`LSU_DATA_W{1'b1}} >> right_shift);

    always_comb begin
        case (sz_q)
            SZ_BYTE: begin
                if (unsigned_q) begin
                    load_data = {{(`LSU_DATA_W-8){1'b0}}, sel_byte};
                end else begin
                    load_data = {{(`LSU_DATA_W-8){sel_byte[7]}}, sel_byte};
                end
            end
            SZ_HALF: begin
                if (unsigned_q) begin
                    load_data = {{(`LSU_DATA_W-16){1'b0}}, sel_half};
                end else begin
                    load_data = {{(`LSU_DATA_W-16){sel_half[15]}}, sel_half};
                end
            end
            SZ_LEFT:  load_data = (mem_rdata_i << left_shift) | (old_q & left_keep);
            SZ_RIGHT: load_data = (mem_rdata_i >> right_shift) | (old_q & right_keep);
            default:  load_data = mem_rdata_i;   // Whole word
        endcase
    end

    assign wb_data_o = (op_q == OP_M2R) ? load_data : old_q;

endmodule

//--- lsu_asserts.sv
`timescale 1ns/1ns

module lsu_asserts (
    input logic clk_i,
    input logic rst_n_i,
    input logic rd_i,
    input logic wr_i,
    input logic align_err_i,
    input logic flush_i,
    input logic wb_en_i
);

    bit   excl_fail;
    bit   blocked_fail;
    bit   reset_fail;
    logic any_fail;

    assign any_fail = excl_fail | blocked_fail | reset_fail;

    // One strobe per access
    a_strobe_excl: assert property (@(posedge clk_i) !(rd_i && wr_i))
        else begin
            $error("read and write strobes high together");
            excl_fail = 1'b1;
        end

    a_blocked_idle: assert property (@(posedge clk_i) (align_err_i || flush_i) |-> !(rd_i || wr_i))
        else begin
            $error("strobe active on a flushed or misaligned access");
            blocked_fail = 1'b1;
        end

    a_wb_after_reset: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !wb_en_i)
        else begin
            $error("writeback enable high right after reset release");
            reset_fail = 1'b1;
        end  // First cycle out of reset

endmodule

// Top level sees the RAM strobes and the writeback side together
bind lsu_top lsu_asserts u_lsu_asserts (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rd_i        (bus_if.rd),
    .wr_i        (bus_if.wr),
    .align_err_i (alignment_err_o),
    .flush_i     (exception_flush_i),
    .wb_en_i     (wb_en_o)
);

//--- lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Datapath word width in bits
`define LSU_DATA_W 32

// Word address bits of the data RAM, 1024 words
`define LSU_RAM_AW 10

`endif

//--- lsu_patterns.mem
// op(0 pass,1 load,2 store) size(0 byte,1 half,2 word,3 left,4 right) unsigned flush
// reg_addr addr data exp_align_err exp_wb_en exp_wb_data, all hex
2 2 0 0 01 00000100 8421F07E 0 0 00000000
1 0 0 0 02 00000101 00000000 0 1 FFFFFFF0
1 0 1 0 03 00000101 00000000 0 1 000000F0
1 0 0 0 04 00000100 00000000 0 1 0000007E
1 0 0 0 05 00000103 00000000 0 1 FFFFFF84
1 0 1 0 06 00000102 00000000 0 1 00000021
1 1 0 0 07 00000102 00000000 0 1 FFFF8421
1 1 1 0 08 00000100 00000000 0 1 0000F07E
2 1 0 0 09 00000102 0000ABCD 0 0 00000000
2 0 0 0 0A 00000101 00000055 0 0 00000000
1 2 0 0 0B 00000100 00000000 0 1 ABCD557E
1 1 0 0 0C 00000100 00000000 0 1 0000557E
2 2 0 0 0D 00000200 AAAAAAAA 0 0 00000000
2 3 0 0 0E 00000200 11223344 0 0 00000000
2 4 0 0 0F 00000203 55667788 0 0 00000000
1 2 0 0 10 00000200 00000000 0 1 88AAAA11
2 3 0 0 11 00000201 11223344 0 0 00000000
2 4 0 0 12 00000202 55667788 0 0 00000000
1 2 0 0 13 00000200 00000000 0 1 77881122
2 3 0 0 14 00000202 11223344 0 0 00000000
2 4 0 0 15 00000201 55667788 0 0 00000000
1 2 0 0 16 00000200 00000000 0 1 66778833
2 3 0 0 17 00000203 11223344 0 0 00000000
1 2 0 0 18 00000200 00000000 0 1 11223344
2 4 0 0 19 00000200 55667788 0 0 00000000
1 2 0 0 1A 00000200 00000000 0 1 55667788
1 3 0 0 1B 00000200 CCDDEEFF 0 1 88DDEEFF
1 3 0 0 1C 00000201 CCDDEEFF 0 1 7788EEFF
1 3 0 0 1D 00000202 CCDDEEFF 0 1 667788FF
1 3 0 0 1E 00000203 CCDDEEFF 0 1 55667788
1 4 0 0 1F 00000200 CCDDEEFF 0 1 55667788
1 4 0 0 01 00000201 CCDDEEFF 0 1 CC556677
1 4 0 0 02 00000202 CCDDEEFF 0 1 CCDD5566
1 4 0 0 03 00000203 CCDDEEFF 0 1 CCDDEE55
2 1 0 0 04 00000201 0000BEEF 1 0 00000000
2 2 0 0 05 00000202 DEADBEEF 1 0 00000000
1 2 0 0 06 00000203 00000000 1 0 00000000
1 1 0 0 07 00000201 00000000 1 0 00000000
1 2 0 0 08 00000200 00000000 0 1 55667788
2 2 0 1 09 00000200 0BADF00D 0 0 00000000
1 2 0 1 0A 00000200 00000000 0 0 00000000
1 2 0 0 0B 00000200 00000000 0 1 55667788
0 2 0 0 0C 00000003 13579BDF 0 1 13579BDF

//--- lsu_pkg.sv
`include "lsu_params.svh"

package lsu_pkg;

    // Operation carried by the instruction into the memory stage
    typedef enum logic [1:0] {
        OP_D2R = 2'd0,  // Register data straight to writeback
        OP_M2R = 2'd1,  // Load
        OP_R2M = 2'd2   // Store
    } access_op_e;

    typedef enum logic [2:0] {
        SZ_BYTE  = 3'd0,
        SZ_HALF  = 3'd1,
        SZ_WORD  = 3'd2,
        SZ_LEFT  = 3'd3,  // Unaligned left part
        SZ_RIGHT = 3'd4   // Unaligned right part
    } access_sz_e;

    // One memory word, seen as lanes or as halves
    typedef union packed {
        logic [`LSU_DATA_W/8-1:0][7:0]   bytes;
        logic [`LSU_DATA_W/16-1:0][15:0] halves;
        logic [`LSU_DATA_W-1:0]          word;
    } mem_word_u;

endpackage

//--- lsu_top.sv
`timescale 1ns/1ns
`include "lsu_params.svh"

module lsu_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  lsu_pkg::access_op_e     mem_access_op_i,
    input  lsu_pkg::access_sz_e     mem_access_sz_i,
    input  logic [`LSU_DATA_W-1:0]  data_i,
    input  logic [4:0]              reg_addr_i,
    input  logic [`LSU_DATA_W-1:0]  addr_i,
    input  logic                    flag_unsigned_i,
    input  logic                    exception_flush_i,
    output logic                    alignment_err_o,
    output logic                    wb_en_o,
    output logic [4:0]              wb_reg_addr_o,
    output logic [`LSU_DATA_W-1:0]  wb_data_o
);

    logic blocked;

    mem_bus_if bus_if ();

    // Flush or misalignment kills access and writeback
    assign blocked = exception_flush_i | alignment_err_o;

    mem_access u_mem_access (
        .mem_access_op_i   (mem_access_op_i),
        .mem_access_sz_i   (mem_access_sz_i),
        .data_i            (data_i),
        .addr_i            (addr_i),
        .exception_flush_i (exception_flush_i),
        .alignment_err_o   (alignment_err_o),
        .bus               (bus_if)
    );

    data_ram #(
        .ADDR_W (`LSU_RAM_AW)
    ) u_data_ram (
        .clk_i (clk_i),
        .bus   (bus_if)
    );

    load_merge u_load_merge (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .mem_access_op_i (mem_access_op_i),
        .mem_access_sz_i (mem_access_sz_i),
        .addr_lo_i       (addr_i[1:0]),
        .flag_unsigned_i (flag_unsigned_i),
        .blocked_i       (blocked),
        .reg_addr_i      (reg_addr_i),
        .data_i          (data_i),
        .mem_rdata_i     (bus_if.rdata),
        .wb_en_o         (wb_en_o),
        .wb_reg_addr_o   (wb_reg_addr_o),
        .wb_data_o       (wb_data_o)
    );

endmodule

//--- mem_access.sv
`timescale 1ns/1ns
`include "lsu_params.svh"

module mem_access (
    input  lsu_pkg::access_op_e     mem_access_op_i,
    input  lsu_pkg::access_sz_e     mem_access_sz_i,
    input  logic [`LSU_DATA_W-1:0]  data_i,
    input  logic [`LSU_DATA_W-1:0]  addr_i,
    input  logic                    exception_flush_i,
    output logic                    alignment_err_o,
    mem_bus_if.master               bus
);
    import lsu_pkg::*;

    logic [1:0] a;
    logic [4:0] left_shift;
    logic [4:0] right_shift;
    logic       is_mem_op;
    logic       blocked;

    assign a           = addr_i[1:0];
    assign left_shift  = {2'd3 - a, 3'b000};   // (3-a) bytes
    assign right_shift = {a, 3'b000};

    assign is_mem_op = (mem_access_op_i == OP_M2R) || (mem_access_op_i == OP_R2M);

    assign alignment_err_o = is_mem_op &&
                             ((mem_access_sz_i == SZ_HALF && a[0]) ||
                              (mem_access_sz_i == SZ_WORD && a != 2'b00));

    assign blocked = exception_flush_i | alignment_err_o;

    // RAM drops the low pair itself
    assign bus.addr = addr_i;

    always_comb begin
        case (mem_access_sz_i)
            SZ_HALF:  bus.byte_en = {a[1], a[1], ~a[1], ~a[1]};
            SZ_BYTE:  bus.byte_en = 4'b0001 << a;
            SZ_LEFT:  bus.byte_en = {a[1] & a[0], a[1], a[1] | a[0], 1'b1};  // Lanes 0..a
            SZ_RIGHT: bus.byte_en = {1'b1, ~(a[1] & a[0]), ~a[1], ~(a[1] | a[0])};
            default:  bus.byte_en = 4'b1111;
        endcase
    end

    always_comb begin
        bus.rd    = 1'b0;
        bus.wr    = 1'b0;
        bus.wdata = '0;
        case (mem_access_op_i)
            OP_M2R: begin
                bus.rd = ~blocked;
            end
            OP_R2M: begin
                bus.wr = ~blocked;
                case (mem_access_sz_i)
                    SZ_WORD:  bus.wdata = data_i;
                    SZ_HALF:  bus.wdata = {2{data_i[15:0]}};
                    SZ_BYTE:  bus.wdata = {4{data_i[7:0]}};
                    SZ_LEFT:  bus.wdata = data_i >> left_shift;  // Upper register bytes down
                    SZ_RIGHT: bus.wdata = data_i << right_shift;
                    default:  bus.wdata = '0;
                endcase
            end
            default: begin
                // Pass-through, no memory traffic
                bus.rd = 1'b0;
            end
        endcase
    end

endmodule

//--- mem_bus_if.sv
`timescale 1ns/1ns
`include "lsu_params.svh"

interface mem_bus_if;

    logic [`LSU_DATA_W-1:0]   addr;     // Byte address
    logic [`LSU_DATA_W-1:0]   wdata;
    logic                     rd;
    logic                     wr;
    logic [`LSU_DATA_W/8-1:0] byte_en;
    logic [`LSU_DATA_W-1:0]   rdata;    // Valid the cycle after rd

    modport master (
        output addr,
        output wdata,
        output rd,
        output wr,
        output byte_en,
        input  rdata
    );

    modport slave (
        input  addr,
        input  wdata,
        input  rd,
        input  wr,
        input  byte_en,
        output rdata
    );

endinterface

//--- tb_lsu.sv
`timescale 1ns/1ns
`include "lsu_params.svh"

module tb_lsu;
    import lsu_pkg::*;

    localparam int FIELDS    = 10;   // Tokens per pattern line
    localparam int MAX_PAT   = 64;
    localparam int RAND_N    = 8;
    localparam int RESET_CYC = 16;
    localparam logic [31:0] ADDR_MASK = 32'((1 << (`LSU_RAM_AW + 2)) - 4);

    logic                   clk;
    logic                   rst_n;
    access_op_e             op;
    access_sz_e             sz;
    logic [`LSU_DATA_W-1:0] data;
    logic [4:0]             reg_addr;
    logic [`LSU_DATA_W-1:0] addr;
    logic                   flag_unsigned;
    logic                   flush;
    logic                   alignment_err;
    logic                   wb_en;
    logic [4:0]             wb_reg_addr;
    logic [`LSU_DATA_W-1:0] wb_data;

    logic [31:0] pat_mem [FIELDS*MAX_PAT];
    logic [31:0] shadow [2**`LSU_RAM_AW];   // Model of the words written in the random phase
    logic [31:0] rand_addr [RAND_N];
    logic [31:0] rnd_state;
    int          num_pat;
    int          base;
    int          req_idx;
    int          cycle_cnt;
    int          cycle_limit;

    // Writeback expected in the cycle after its request
    logic        pend_valid;
    int          pend_idx;
    logic        pend_en;
    logic [4:0]  pend_reg;
    logic [31:0] pend_data;

    lsu_top dut (
        .clk_i             (clk),
        .rst_n_i           (rst_n),
        .mem_access_op_i   (op),
        .mem_access_sz_i   (sz),
        .data_i            (data),
        .reg_addr_i        (reg_addr),
        .addr_i            (addr),
        .flag_unsigned_i   (flag_unsigned),
        .exception_flush_i (flush),
        .alignment_err_o   (alignment_err),
        .wb_en_o           (wb_en),
        .wb_reg_addr_o     (wb_reg_addr),
        .wb_data_o         (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        forever begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
            if (dut.u_lsu_asserts.any_fail) begin
                $display("A bound assertion failed during the run");
                $display("TEST FAILED");
                $fatal(1, "assertion failure");
            end
            if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
                $display("Timeout: the run did not end within %0d cycles", cycle_limit);
                $display("TEST FAILED");
                $fatal(1, "timeout");
            end
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %08h, expected %08h",
                     $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_writeback();
        if (pend_valid) begin
            check_value({31'd0, wb_en}, {31'd0, pend_en}, $sformatf("req %0d wb_en_o", pend_idx));
            check_value({27'd0, wb_reg_addr}, {27'd0, pend_reg},
                        $sformatf("req %0d wb_reg_addr_o", pend_idx));
            if (pend_en) begin
                check_value(wb_data, pend_data, $sformatf("req %0d wb_data_o", pend_idx));
            end
        end
    endtask

    // One request per cycle with the previous writeback checked alongside
    task automatic apply_request(input logic [31:0] f_op, f_sz, f_uns, f_flush, f_reg,
                                 input logic [31:0] f_addr, f_data, f_err, f_en, f_wb);
        @(posedge clk);
        op            <= access_op_e'(f_op[1:0]);
        sz            <= access_sz_e'(f_sz[2:0]);
        flag_unsigned <= f_uns[0];
        flush         <= f_flush[0];
        reg_addr      <= f_reg[4:0];
        addr          <= f_addr;
        data          <= f_data;
        @(negedge clk);
        check_value({31'd0, alignment_err}, f_err, $sformatf("req %0d alignment_err_o", req_idx));
        check_writeback();
        pend_valid = 1'b1;
        pend_idx   = req_idx;
        pend_en    = f_en[0];
        pend_reg   = f_reg[4:0];
        pend_data  = f_wb;
        req_idx    = req_idx + 1;
    endtask

    task automatic drain_pipeline();
        @(posedge clk);
        op    <= OP_D2R;
        flush <= 1'b1;
        @(negedge clk);
        check_writeback();
        pend_valid = 1'b0;
    endtask

    initial begin
        cycle_limit   = 0;
        req_idx       = 0;
        pend_valid    = 1'b0;
        pend_idx      = 0;
        pend_en       = 1'b0;
        pend_reg      = 5'd0;
        pend_data     = '0;
        rst_n         = 1'b0;
        op            = OP_D2R;
        sz            = SZ_WORD;
        data          = '0;
        reg_addr      = 5'd0;
        addr          = '0;
        flag_unsigned = 1'b0;
        flush         = 1'b0;

        for (int i = 0; i < FIELDS * MAX_PAT; i++) begin
            pat_mem[i] = 32'hFFFF_FFFF;   // End marker where no line was read
        end
        $readmemh("lsu_patterns.mem", pat_mem);
        num_pat = 0;
        while (num_pat < MAX_PAT && pat_mem[num_pat*FIELDS] !== 32'hFFFF_FFFF) begin
            num_pat = num_pat + 1;
        end
        if (num_pat == 0) begin
            $display("No patterns could be read from lsu_patterns.mem");
            $display("TEST FAILED");
            $fatal(1, "no stimulus");
        end
        cycle_limit = RESET_CYC + num_pat + 2 * RAND_N + 50;

        repeat (RESET_CYC) @(posedge clk);
        rst_n <= 1'b1;

        for (int p = 0; p < num_pat; p++) begin
            base = p * FIELDS;
            apply_request(pat_mem[base], pat_mem[base+1], pat_mem[base+2], pat_mem[base+3],
                          pat_mem[base+4], pat_mem[base+5], pat_mem[base+6], pat_mem[base+7],
                          pat_mem[base+8], pat_mem[base+9]);
        end

        // Random word stores followed by loads of the same words
        rnd_state = 32'd27;
        for (int i = 0; i < RAND_N; i++) begin
            rnd_state    = xorshift32(rnd_state);
            rand_addr[i] = rnd_state & ADDR_MASK;
            rnd_state    = xorshift32(rnd_state);
            shadow[rand_addr[i][`LSU_RAM_AW+1:2]] = rnd_state;
            apply_request(2, 2, 0, 0, i, rand_addr[i], rnd_state, 0, 0, 0);
        end
        for (int i = 0; i < RAND_N; i++) begin
            apply_request(1, 2, 0, 0, i + 16, rand_addr[i], 0, 0, 1,
                          shadow[rand_addr[i][`LSU_RAM_AW+1:2]]);
        end
        drain_pipeline();

        if (dut.u_lsu_asserts.any_fail) begin
            $display("A bound assertion failed during the run");
            $display("TEST FAILED");
            $fatal(1, "assertion failure");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule
